// File: sim.f
hw/cpu_queue_pkg.sv
hw/cpu_queue_regs_pkg.sv
hw/queue_stat_if.sv
hw/pkt_fifo.sv
hw/tx_watchdog.sv
hw/cpu_dma_queue.sv
hw/cpu_queue_regs.sv
hw/cpu_dma_queue_top.sv
testbench/cpu_dma_queue_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := cpu_dma_queue_tb
FILE_LIST  := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/cpu_dma_queue_tb.sv
// cpu_dma_queue_tb: table-driven testbench with packet model, apb tasks and checks

`timescale 1ns/10ps

module cpu_dma_queue_tb;

   localparam int DATA_WIDTH      = 64;
   localparam int CTRL_WIDTH      = DATA_WIDTH / 8;
   localparam int FIFO_ADDR_WIDTH = 5;
   localparam int WD_LIMIT_RESET  = 1000;
   localparam int WD_LIMIT_TEST   = 20;
   localparam int TIMEOUT_CYCLES  = 300;
   localparam int NUM_ROWS        = 8;
   localparam int SAMPLE_DELAY    = 2;

   // one row per packet: direction, words, out_rdy stall percent, no last word
   typedef struct packed {
      bit       is_tx;
      bit [7:0] len;
      bit [7:0] stall_pct;
      bit       incomplete;
   } stim_row_t;

   localparam stim_row_t STIM [NUM_ROWS] = '{
      '{1'b0, 8'd1,  8'd0,  1'b0},
      '{1'b0, 8'd5,  8'd0,  1'b0},
      '{1'b0, 8'd12, 8'd0,  1'b0},
      '{1'b1, 8'd1,  8'd0,  1'b0},
      '{1'b1, 8'd6,  8'd50, 1'b0},
      '{1'b1, 8'd10, 8'd80, 1'b0},
      // partial packet, left for the watchdog
      '{1'b1, 8'd3,  8'd0,  1'b1},
      '{1'b1, 8'd4,  8'd30, 1'b0}
   };

   logic                  clk = 1'b0;
   logic                  reset;
   logic [DATA_WIDTH-1:0] in_data, out_data, cpu_q_dma_rd_data, cpu_q_dma_wr_data;
   logic [CTRL_WIDTH-1:0] in_ctrl, out_ctrl, cpu_q_dma_rd_ctrl, cpu_q_dma_wr_ctrl;
   logic                  in_wr, in_rdy, out_wr, out_rdy;
   logic                  cpu_q_dma_pkt_avail, cpu_q_dma_nearly_full;
   logic                  cpu_q_dma_rd, cpu_q_dma_wr;
   logic [7:0]            paddr;
   logic                  psel, penable, pwrite, pready, pslverr;
   logic [31:0]           pwdata, prdata;

   // expected words, in arrival order
   logic [DATA_WIDTH-1:0] rx_exp_data [$];
   logic [CTRL_WIDTH-1:0] rx_exp_ctrl [$];
   logic [DATA_WIDTH-1:0] tx_exp_data [$];
   logic [CTRL_WIDTH-1:0] tx_exp_ctrl [$];

   // model packet counts
   int rx_stored_cnt = 0;
   int rx_pulled_cnt = 0;
   int tx_stored_cnt = 0;
   int tx_sent_cnt   = 0;
   int timeout_cnt   = 0;

   cpu_dma_queue_top #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH),
      .WD_LIMIT_RESET  (WD_LIMIT_RESET)
   ) cpu_dma_queue_top_i (.*);

   // 8 ns period
   always #4 clk = ~clk;

   ////////////////////////////////////////
   // reference rules and checks
   ////////////////////////////////////////

   // datapath byte i lands in host byte N-1-i
   function automatic logic [DATA_WIDTH-1:0] swap_bytes(input logic [DATA_WIDTH-1:0] d);
      logic [DATA_WIDTH-1:0] r;
      for (int i = 0; i < CTRL_WIDTH; i++) begin
         r[8*(CTRL_WIDTH-1-i) +: 8] = d[8*i +: 8];
      end
      return r;
   endfunction

   function automatic logic [CTRL_WIDTH-1:0] swap_ctrl(input logic [CTRL_WIDTH-1:0] c);
      logic [CTRL_WIDTH-1:0] r;
      for (int i = 0; i < CTRL_WIDTH; i++) begin
         r[CTRL_WIDTH-1-i] = c[i];
      end
      return r;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected) else begin
         report_failure($sformatf("mismatch at %0t ns: %s expected %0h actual %0h",
                                  $time, name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      check_value(name, {63'd0, expected}, {63'd0, actual});
   endtask

   ////////////////////////////////////////
   // apb master
   ////////////////////////////////////////

   // setup phase, access phase, sample once the access edge has passed
   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      // zero wait states, access completes at the next rising edge
      @(negedge clk);
      check_bit("pready", 1'b1, pready);
      rdata   = prdata;
      err     = pslverr;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b1, addr, data, rdata, err);
      check_bit($sformatf("pslverr on write to %0h", addr), exp_err, err);
   endtask

   task automatic reg_read_check(input logic [7:0] addr, input logic [31:0] expected,
                                 input string name);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b0, addr, '0, rdata, err);
      check_bit({"pslverr on read of ", name}, 1'b0, err);
      check_value(name, {32'd0, expected}, {32'd0, rdata});
   endtask

   ////////////////////////////////////////
   // rx: in stream -> dma read
   ////////////////////////////////////////

   task automatic send_rx_packet(input stim_row_t row);
      logic [DATA_WIDTH-1:0] d;
      logic [CTRL_WIDTH-1:0] c;
      int                    wait_cnt;
      for (int w = 0; w < row.len; w++) begin
         d = {$urandom, $urandom};
         c = (w == row.len - 1) ? CTRL_WIDTH'($urandom % 255 + 1) : '0;
         wait_cnt = 0;
         @(negedge clk);
         while (!in_rdy) begin
            in_wr = 1'b0;
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) report_failure("in_rdy stayed low too long");
            @(negedge clk);
         end
         in_wr   = 1'b1;
         in_data = d;
         in_ctrl = c;
         rx_exp_data.push_back(swap_bytes(d));
         rx_exp_ctrl.push_back(swap_ctrl(c));
      end
      @(negedge clk);
      in_wr = 1'b0;
      rx_stored_cnt++;
   endtask

   // pull every queued packet, then pkt_avail must fall
   task automatic drain_rx();
      logic [DATA_WIDTH-1:0] exp_d;
      logic [CTRL_WIDTH-1:0] exp_c;
      int                    wait_cnt;
      while (rx_exp_data.size() > 0) begin
         wait_cnt = 0;
         @(negedge clk);
         while (!cpu_q_dma_pkt_avail) begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) report_failure("no rx packet became available");
            @(negedge clk);
         end
         // head word is valid before each pop
         do begin
            exp_d = rx_exp_data.pop_front();
            exp_c = rx_exp_ctrl.pop_front();
            check_value("cpu_q_dma_rd_data", exp_d, cpu_q_dma_rd_data);
            check_value("cpu_q_dma_rd_ctrl", 64'(exp_c), 64'(cpu_q_dma_rd_ctrl));
            cpu_q_dma_rd = 1'b1;
            @(negedge clk);
         end while (exp_c == '0);
         cpu_q_dma_rd = 1'b0;
         rx_pulled_cnt++;
      end
      wait_cnt = 0;
      while (cpu_q_dma_pkt_avail) begin
         wait_cnt++;
         if (wait_cnt > TIMEOUT_CYCLES) report_failure("pkt_avail stayed high after drain");
         @(negedge clk);
      end
   endtask

   ////////////////////////////////////////
   // tx: dma write -> out stream
   ////////////////////////////////////////

   // host order in, datapath order out, bytes and ctrl reversed
   task automatic send_tx_packet(input stim_row_t row);
      logic [DATA_WIDTH-1:0] d;
      logic [CTRL_WIDTH-1:0] c;
      int                    wait_cnt;
      for (int w = 0; w < row.len; w++) begin
         d = {$urandom, $urandom};
         c = (w == row.len - 1 && !row.incomplete) ? CTRL_WIDTH'($urandom % 255 + 1) : '0;
         wait_cnt = 0;
         @(negedge clk);
         while (cpu_q_dma_nearly_full) begin
            cpu_q_dma_wr = 1'b0;
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) report_failure("tx fifo stayed nearly full");
            @(negedge clk);
         end
         cpu_q_dma_wr      = 1'b1;
         cpu_q_dma_wr_data = d;
         cpu_q_dma_wr_ctrl = c;
         if (!row.incomplete) begin
            tx_exp_data.push_back(swap_bytes(d));
            tx_exp_ctrl.push_back(swap_ctrl(c));
         end
      end
      @(negedge clk);
      cpu_q_dma_wr = 1'b0;
      if (!row.incomplete) tx_stored_cnt++;
   endtask

   // random out_rdy stalls, one packet expected
   task automatic collect_tx(input bit [7:0] stall_pct);
      logic [DATA_WIDTH-1:0] exp_d;
      logic [CTRL_WIDTH-1:0] exp_c;
      int                    wait_cnt;
      logic                  done;
      wait_cnt = 0;
      done     = 1'b0;
      while (!done) begin
         @(negedge clk);
         out_rdy = (($urandom % 100) >= stall_pct);
         // outputs settled, well before the edge that moves the word
         #SAMPLE_DELAY;
         if (out_wr) begin
            exp_d = tx_exp_data.pop_front();
            exp_c = tx_exp_ctrl.pop_front();
            check_value("out_data", exp_d, out_data);
            check_value("out_ctrl", 64'(exp_c), 64'(out_ctrl));
            done     = (exp_c != '0);
            wait_cnt = 0;
         end else begin
            wait_cnt++;
            if (wait_cnt > TIMEOUT_CYCLES) report_failure("tx packet never left on out");
         end
      end
      tx_sent_cnt++;
      // no duplicate words once the packet is gone
      @(negedge clk);
      out_rdy = 1'b1;
      repeat (4) begin
         @(negedge clk);
         check_bit("out_wr", 1'b0, out_wr);
      end
      out_rdy = 1'b0;
   endtask

   // partial packet must stay put, then the flush shows up in the counter
   task automatic wait_tx_flush();
      logic [31:0] rdata;
      logic        err;
      int          polls;
      @(negedge clk);
      out_rdy = 1'b1;
      repeat (WD_LIMIT_TEST / 2) begin
         @(negedge clk);
         check_bit("out_wr", 1'b0, out_wr);
      end
      rdata = '0;
      polls = 0;
      while (rdata == '0) begin
         polls++;
         if (polls > 100) report_failure("watchdog never flushed the partial tx packet");
         apb_access(1'b0, cpu_queue_regs_pkg::REG_TX_TIMEOUTS, '0, rdata, err);
      end
      out_rdy = 1'b0;
      timeout_cnt++;
      check_value("REG_TX_TIMEOUTS", 64'(timeout_cnt), {32'd0, rdata});
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0] rdata;
      logic        err;
      void'($urandom(32'h26758f74));
      reset             = 1'b1;
      in_data           = '0;
      in_ctrl           = '0;
      in_wr             = 1'b0;
      out_rdy           = 1'b0;
      cpu_q_dma_rd      = 1'b0;
      cpu_q_dma_wr      = 1'b0;
      cpu_q_dma_wr_data = '0;
      cpu_q_dma_wr_ctrl = '0;
      paddr             = '0;
      psel              = 1'b0;
      penable           = 1'b0;
      pwrite            = 1'b0;
      pwdata            = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // queues disabled out of reset
      repeat (4) begin
         @(negedge clk);
         check_bit("in_rdy", 1'b0, in_rdy);
         check_bit("out_wr", 1'b0, out_wr);
         check_bit("cpu_q_dma_pkt_avail", 1'b0, cpu_q_dma_pkt_avail);
         check_bit("cpu_q_dma_nearly_full", 1'b0, cpu_q_dma_nearly_full);
         check_bit("pslverr", 1'b0, pslverr);
      end
      reg_read_check(cpu_queue_regs_pkg::REG_CTRL, 32'd0, "REG_CTRL");
      reg_read_check(cpu_queue_regs_pkg::REG_WD_LIMIT, WD_LIMIT_RESET, "REG_WD_LIMIT");
      check_bit("in_rdy", 1'b0, in_rdy);

      // short limit so the partial packet is flushed quickly
      reg_write(cpu_queue_regs_pkg::REG_WD_LIMIT, WD_LIMIT_TEST, 1'b0);
      reg_write(cpu_queue_regs_pkg::REG_CTRL, 32'h3, 1'b0);

      for (int i = 0; i < NUM_ROWS; i++) begin
         if (STIM[i].is_tx) begin
            send_tx_packet(STIM[i]);
            if (STIM[i].incomplete) begin
               wait_tx_flush();
            end else begin
               collect_tx(STIM[i].stall_pct);
            end
         end else begin
            send_rx_packet(STIM[i]);
            // rx packets pile up until the run of rx rows ends
            if (i == NUM_ROWS - 1 || STIM[i+1].is_tx) drain_rx();
         end
      end

      // event counters against the model
      reg_read_check(cpu_queue_regs_pkg::REG_RX_STORED, rx_stored_cnt, "REG_RX_STORED");
      reg_read_check(cpu_queue_regs_pkg::REG_RX_PULLED, rx_pulled_cnt, "REG_RX_PULLED");
      reg_read_check(cpu_queue_regs_pkg::REG_TX_STORED, tx_stored_cnt, "REG_TX_STORED");
      reg_read_check(cpu_queue_regs_pkg::REG_TX_SENT, tx_sent_cnt, "REG_TX_SENT");
      reg_read_check(cpu_queue_regs_pkg::REG_TX_TIMEOUTS, timeout_cnt, "REG_TX_TIMEOUTS");

      // counters are read only, unmapped space is rejected
      reg_write(cpu_queue_regs_pkg::REG_RX_STORED, 32'hdead_beef, 1'b1);
      reg_read_check(cpu_queue_regs_pkg::REG_RX_STORED, rx_stored_cnt, "REG_RX_STORED");
      reg_write(8'h40, 32'h0000_0000, 1'b1);
      apb_access(1'b0, 8'h40, '0, rdata, err);
      check_bit("pslverr on unmapped read", 1'b1, err);
      check_value("prdata of unmapped read", 64'd0, {32'd0, rdata});
      reg_read_check(cpu_queue_regs_pkg::REG_CTRL, 32'h3, "REG_CTRL");
      reg_read_check(cpu_queue_regs_pkg::REG_WD_LIMIT, WD_LIMIT_TEST, "REG_WD_LIMIT");

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: hw/cpu_dma_queue_top.sv
// cpu_dma_queue_top: queue datapath plus apb register block

`timescale 1ns/10ps

module cpu_dma_queue_top #(
   parameter int          DATA_WIDTH      = 64,
   parameter int          FIFO_ADDR_WIDTH = 5,
   parameter int unsigned WD_LIMIT_RESET  = 1000
) (
   input  logic                                         clk,
   input  logic                                         reset,
   // datapath streams
   input  logic [DATA_WIDTH-1:0]                        in_data,
   input  logic [DATA_WIDTH/8-1:0]                      in_ctrl,
   input  logic                                         in_wr,
   output logic                                         in_rdy,
   output logic [DATA_WIDTH-1:0]                        out_data,
   output logic [DATA_WIDTH/8-1:0]                      out_ctrl,
   output logic                                         out_wr,
   input  logic                                         out_rdy,
   // host dma
   output logic                                         cpu_q_dma_pkt_avail,
   output logic                                         cpu_q_dma_nearly_full,
   input  logic                                         cpu_q_dma_rd,
   output logic [DATA_WIDTH-1:0]                        cpu_q_dma_rd_data,
   output logic [DATA_WIDTH/8-1:0]                      cpu_q_dma_rd_ctrl,
   input  logic                                         cpu_q_dma_wr,
   input  logic [DATA_WIDTH-1:0]                        cpu_q_dma_wr_data,
   input  logic [DATA_WIDTH/8-1:0]                      cpu_q_dma_wr_ctrl,
   // apb
   input  logic [cpu_queue_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
   input  logic                                         psel,
   input  logic                                         penable,
   input  logic                                         pwrite,
   input  logic [31:0]                                  pwdata,
   output logic [31:0]                                  prdata,
   output logic                                         pready,
   output logic                                         pslverr
);

   // enables and limit one way, event pulses the other
   queue_stat_if stat_if ();

   cpu_dma_queue #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
   ) queue_i (
      .clk                   (clk),
      .reset                 (reset),
      .in_data               (in_data),
      .in_ctrl               (in_ctrl),
      .in_wr                 (in_wr),
      .in_rdy                (in_rdy),
      .out_data              (out_data),
      .out_ctrl              (out_ctrl),
      .out_wr                (out_wr),
      .out_rdy               (out_rdy),
      .cpu_q_dma_pkt_avail   (cpu_q_dma_pkt_avail),
      .cpu_q_dma_nearly_full (cpu_q_dma_nearly_full),
      .cpu_q_dma_rd          (cpu_q_dma_rd),
      .cpu_q_dma_rd_data     (cpu_q_dma_rd_data),
      .cpu_q_dma_rd_ctrl     (cpu_q_dma_rd_ctrl),
      .cpu_q_dma_wr          (cpu_q_dma_wr),
      .cpu_q_dma_wr_data     (cpu_q_dma_wr_data),
      .cpu_q_dma_wr_ctrl     (cpu_q_dma_wr_ctrl),
      .stat                  (stat_if.queue)
   );

   cpu_queue_regs #(
      .WD_LIMIT_RESET (WD_LIMIT_RESET)
   ) regs_i (
      .clk     (clk),
      .reset   (reset),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .stat    (stat_if.regs)
   );

endmodule

// File: hw/cpu_queue_regs.sv
// cpu_queue_regs: apb slave with control, watchdog limit and event counters

`timescale 1ns/10ps

module cpu_queue_regs #(
   parameter int unsigned WD_LIMIT_RESET = 1000
) (
   input  logic                                         clk,
   input  logic                                         reset,
   input  logic [cpu_queue_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
   input  logic                                         psel,
   input  logic                                         penable,
   input  logic                                         pwrite,
   input  logic [31:0]                                  pwdata,
   output logic [31:0]                                  prdata,
   output logic                                         pready,
   output logic                                         pslverr,
   queue_stat_if.regs                                   stat
);

   localparam int WDW     = cpu_queue_pkg::WD_TIMER_WIDTH;
   localparam int NUM_EVT = 5;

   logic [31:0]        evt_cnt [NUM_EVT];
   logic [NUM_EVT-1:0] evt;
   logic [31:0]        rd_mux;
   logic               addr_ok;
   logic               addr_rw;
   logic               wr_ok;

   // counter order matches the register map
   assign evt = {stat.tx_timeout, stat.tx_pkt_sent, stat.tx_pkt_stored,
                 stat.rx_pkt_pulled, stat.rx_pkt_stored};

   ////////////////////////////////////////
   // address decode
   ////////////////////////////////////////

   always_comb begin
      addr_ok = 1'b1;
      addr_rw = 1'b0;
      rd_mux  = '0;
      case (paddr)
         cpu_queue_regs_pkg::REG_CTRL: begin
            addr_rw = 1'b1;
            rd_mux[cpu_queue_regs_pkg::CTRL_RX_EN_BIT] = stat.rx_en;
            rd_mux[cpu_queue_regs_pkg::CTRL_TX_EN_BIT] = stat.tx_en;
         end
         cpu_queue_regs_pkg::REG_WD_LIMIT: begin
            addr_rw = 1'b1;
            rd_mux  = 32'(stat.wd_limit);
         end
         cpu_queue_regs_pkg::REG_RX_STORED:   rd_mux = evt_cnt[0];
         cpu_queue_regs_pkg::REG_RX_PULLED:   rd_mux = evt_cnt[1];
         cpu_queue_regs_pkg::REG_TX_STORED:   rd_mux = evt_cnt[2];
         cpu_queue_regs_pkg::REG_TX_SENT:     rd_mux = evt_cnt[3];
         cpu_queue_regs_pkg::REG_TX_TIMEOUTS: rd_mux = evt_cnt[4];
         default: addr_ok = 1'b0;
      endcase
   end

   // zero wait states
   assign pready  = 1'b1;
   // unmapped, or a write to a read-only counter
   assign pslverr = psel && penable && (!addr_ok || (pwrite && !addr_rw));
   // unmapped reads give zero through rd_mux default
   assign prdata  = (psel && !pwrite) ? rd_mux : '0;
   assign wr_ok   = psel && penable && pwrite && addr_rw;

   ////////////////////////////////////////
   // control registers
   ////////////////////////////////////////

   // both queues come up disabled
   always_ff @(posedge clk) begin
      if (reset) begin
         stat.rx_en    <= 1'b0;
         stat.tx_en    <= 1'b0;
         stat.wd_limit <= WDW'(WD_LIMIT_RESET);
      end else if (wr_ok) begin
         if (paddr == cpu_queue_regs_pkg::REG_CTRL) begin
            stat.rx_en <= pwdata[cpu_queue_regs_pkg::CTRL_RX_EN_BIT];
            stat.tx_en <= pwdata[cpu_queue_regs_pkg::CTRL_TX_EN_BIT];
         end else begin
            stat.wd_limit <= pwdata[WDW-1:0];
         end
      end
   end

   // wrapping event counters, one cycle after each pulse
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_EVT; i++) begin
         if (reset) begin
            evt_cnt[i] <= '0;
         end else if (evt[i]) begin
            evt_cnt[i] <= evt_cnt[i] + 32'd1;
         end
      end
   end

   a_apb_setup: assert property (@(posedge clk) disable iff (reset)
      penable |-> psel);

endmodule

// File: hw/cpu_dma_queue.sv
// cpu_dma_queue: byte reordering, rx/tx packet fifos, handshakes, tx watchdog

`timescale 1ns/10ps

module cpu_dma_queue #(
   parameter int DATA_WIDTH      = 64,
   parameter int FIFO_ADDR_WIDTH = 5
) (
   input  logic                    clk,
   input  logic                    reset,
   // datapath in stream, big-endian
   input  logic [DATA_WIDTH-1:0]   in_data,
   input  logic [DATA_WIDTH/8-1:0] in_ctrl,
   input  logic                    in_wr,
   output logic                    in_rdy,
   // datapath out stream
   output logic [DATA_WIDTH-1:0]   out_data,
   output logic [DATA_WIDTH/8-1:0] out_ctrl,
   output logic                    out_wr,
   input  logic                    out_rdy,
   // dma status
   output logic                    cpu_q_dma_pkt_avail,
   output logic                    cpu_q_dma_nearly_full,
   // dma read of rx fifo, little-endian
   input  logic                    cpu_q_dma_rd,
   output logic [DATA_WIDTH-1:0]   cpu_q_dma_rd_data,
   output logic [DATA_WIDTH/8-1:0] cpu_q_dma_rd_ctrl,
   // dma write of tx fifo
   input  logic                    cpu_q_dma_wr,
   input  logic [DATA_WIDTH-1:0]   cpu_q_dma_wr_data,
   input  logic [DATA_WIDTH/8-1:0] cpu_q_dma_wr_ctrl,
   queue_stat_if.queue             stat
);

   localparam int CTRL_WIDTH = DATA_WIDTH / 8;

   logic                  rx_wr, rx_rd;
   logic                  rx_empty, rx_almost_full, rx_pkt_avail;
   logic [DATA_WIDTH-1:0] rx_din_data;
   logic [CTRL_WIDTH-1:0] rx_din_ctrl;

   logic                  tx_wr, tx_rd;
   logic                  tx_empty, tx_full, tx_almost_full, tx_pkt_avail;
   logic [DATA_WIDTH-1:0] tx_head_data;
   logic [CTRL_WIDTH-1:0] tx_head_ctrl;

   ////////////////////////////////////////
   // byte order
   ////////////////////////////////////////

   // byte i <-> byte N-1-i, ctrl bit i <-> bit N-1-i
   assign rx_din_data = {<<8{in_data}};
   assign rx_din_ctrl = {<<{in_ctrl}};
   // tx reversed on entry, head already in datapath order
   assign out_data    = tx_head_data;
   assign out_ctrl    = tx_head_ctrl;

   ////////////////////////////////////////
   // rx: datapath -> host
   ////////////////////////////////////////

   assign in_rdy = stat.rx_en && !rx_almost_full;
   assign rx_wr  = in_wr && in_rdy;
   // pop of an empty fifo dropped here
   assign rx_rd  = cpu_q_dma_rd && !rx_empty;

   pkt_fifo #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
   ) rx_fifo (
      .clk         (clk),
      .reset       (reset),
      .flush       (1'b0),
      .wr_en       (rx_wr),
      .wr_data     (rx_din_data),
      .wr_ctrl     (rx_din_ctrl),
      .rd_en       (rx_rd),
      .rd_data     (cpu_q_dma_rd_data),
      .rd_ctrl     (cpu_q_dma_rd_ctrl),
      .empty       (rx_empty),
      .full        (),
      .almost_full (rx_almost_full),
      .pkt_avail   (rx_pkt_avail)
   );

   ////////////////////////////////////////
   // tx: host -> datapath
   ////////////////////////////////////////

   assign tx_wr  = cpu_q_dma_wr && !tx_full;
   // release only whole packets
   assign tx_rd  = stat.tx_en && out_rdy && tx_pkt_avail;
   assign out_wr = tx_rd;

   pkt_fifo #(
      .DATA_WIDTH      (DATA_WIDTH),
      .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
   ) tx_fifo (
      .clk         (clk),
      .reset       (reset),
      .flush       (stat.tx_timeout),
      .wr_en       (tx_wr),
      .wr_data     ({<<8{cpu_q_dma_wr_data}}),
      .wr_ctrl     ({<<{cpu_q_dma_wr_ctrl}}),
      .rd_en       (tx_rd),
      .rd_data     (tx_head_data),
      .rd_ctrl     (tx_head_ctrl),
      .empty       (tx_empty),
      .full        (tx_full),
      .almost_full (tx_almost_full),
      .pkt_avail   (tx_pkt_avail)
   );

   // any tx movement restarts the timer
   tx_watchdog tx_watchdog_i (
      .clk        (clk),
      .reset      (reset),
      .activity   (tx_wr || tx_rd),
      .fifo_empty (tx_empty),
      .pkt_avail  (tx_pkt_avail),
      .limit      (stat.wd_limit),
      .timeout    (stat.tx_timeout)
   );

   // dma flags, one cycle behind the fifo
   always_ff @(posedge clk) begin
      if (reset) begin
         cpu_q_dma_pkt_avail   <= 1'b0;
         cpu_q_dma_nearly_full <= 1'b0;
      end else begin
         cpu_q_dma_pkt_avail   <= rx_pkt_avail;
         cpu_q_dma_nearly_full <= tx_almost_full;
      end
   end

   // event pulses on last words
   assign stat.rx_pkt_stored = rx_wr && (|in_ctrl);
   assign stat.rx_pkt_pulled = rx_rd && (|cpu_q_dma_rd_ctrl);
   assign stat.tx_pkt_stored = tx_wr && (|cpu_q_dma_wr_ctrl);
   assign stat.tx_pkt_sent   = tx_rd && (|out_ctrl);

   // source must honour in_rdy, set by enable and fill level
   a_in_wr_rdy: assert property (@(posedge clk) disable iff (reset)
      in_wr |-> in_rdy);

endmodule

// File: hw/tx_watchdog.sv
// tx_watchdog: lock-up detector for the tx fifo, one-cycle flush pulse

`timescale 1ns/10ps

module tx_watchdog (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     activity,
   input  logic                                     fifo_empty,
   input  logic                                     pkt_avail,
   input  logic [cpu_queue_pkg::WD_TIMER_WIDTH-1:0] limit,
   output logic                                     timeout
);

   logic [cpu_queue_pkg::WD_TIMER_WIDTH-1:0] timer;

   // lock-up: words stored but no whole packet to drain
   // dma cannot start a new packet, out cannot release this one
   always_ff @(posedge clk) begin
      if (reset || activity) begin
         timer   <= limit;
         timeout <= 1'b0;
      end else begin
         // hold at zero, only count while something is stuck
         if (!fifo_empty && (timer != '0)) begin
            timer <= timer - 1'b1;
         end
         // single pulse, the flush empties the fifo next cycle
         timeout <= (timer == '0) && !fifo_empty && !pkt_avail && !timeout;
      end
   end

   // pulse has flushed the fifo by the following cycle
   a_single_pulse: assert property (@(posedge clk) disable iff (reset)
      timeout |=> (fifo_empty && !timeout));

endmodule

// File: hw/pkt_fifo.sv
// pkt_fifo: synchronous fwft fifo with flush, almost-full and packet counter

`timescale 1ns/10ps

module pkt_fifo #(
   parameter int DATA_WIDTH      = 64,
   parameter int FIFO_ADDR_WIDTH = 5
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    flush,
   input  logic                    wr_en,
   input  logic [DATA_WIDTH-1:0]   wr_data,
   input  logic [DATA_WIDTH/8-1:0] wr_ctrl,
   input  logic                    rd_en,
   output logic [DATA_WIDTH-1:0]   rd_data,
   output logic [DATA_WIDTH/8-1:0] rd_ctrl,
   output logic                    empty,
   output logic                    full,
   output logic                    almost_full,
   output logic                    pkt_avail
);

   localparam int CTRL_WIDTH = DATA_WIDTH / 8;
   localparam int DEPTH      = 2 ** FIFO_ADDR_WIDTH;
   localparam logic [FIFO_ADDR_WIDTH:0] AF_LEVEL =
      (FIFO_ADDR_WIDTH+1)'(DEPTH - cpu_queue_pkg::FIFO_SLACK);

   // ctrl stored beside data in the same slot
   logic [DATA_WIDTH-1:0] mem_data [DEPTH];
   logic [CTRL_WIDTH-1:0] mem_ctrl [DEPTH];

   // extra msb tells full from empty
   logic [FIFO_ADDR_WIDTH:0] wr_ptr;
   logic [FIFO_ADDR_WIDTH:0] rd_ptr;
   logic [FIFO_ADDR_WIDTH:0] fill;

   logic [cpu_queue_pkg::PKT_CNT_WIDTH-1:0] pkt_cnt;
   logic                                    pkt_in_q;
   logic                                    pkt_out;

   assign fill        = wr_ptr - rd_ptr;
   assign empty       = (fill == '0);
   assign full        = fill[FIFO_ADDR_WIDTH];
   assign almost_full = (fill >= AF_LEVEL);
   assign pkt_avail   = |pkt_cnt;

   // head word falls through, visible the cycle after its write
   assign rd_data = mem_data[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
   assign rd_ctrl = mem_ctrl[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

   // last word leaving
   assign pkt_out = rd_en && (|rd_ctrl);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_data[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= wr_data;
         mem_ctrl[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= wr_ctrl;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         pkt_in_q <= 1'b0;
         pkt_cnt  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // count lags the last-word write by one cycle
         pkt_in_q <= wr_en && (|wr_ctrl);
         case ({pkt_in_q, pkt_out})
            2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
            2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
            default: pkt_cnt <= pkt_cnt;
         endcase
      end
   end

   // caller gates writes with full
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      !(wr_en && full));

   // a packet can only leave once it has been counted in
   a_no_cnt_underflow: assert property (@(posedge clk) disable iff (reset || flush)
      (pkt_out && !pkt_in_q) |-> (pkt_cnt != '0));

endmodule

// File: hw/queue_stat_if.sv
// queue_stat_if: enables, watchdog limit and packet event pulses

`timescale 1ns/10ps

interface queue_stat_if;

   // control, driven by the register block
   logic                                     rx_en;
   logic                                     tx_en;
   logic [cpu_queue_pkg::WD_TIMER_WIDTH-1:0] wd_limit;

   // one-cycle event pulses, driven by the queue
   logic rx_pkt_stored;
   logic rx_pkt_pulled;
   logic tx_pkt_stored;
   logic tx_pkt_sent;
   logic tx_timeout;

   modport queue (
      input  rx_en, tx_en, wd_limit,
      output rx_pkt_stored, rx_pkt_pulled, tx_pkt_stored, tx_pkt_sent, tx_timeout
   );

   modport regs (
      output rx_en, tx_en, wd_limit,
      input  rx_pkt_stored, rx_pkt_pulled, tx_pkt_stored, tx_pkt_sent, tx_timeout
   );

endinterface

// File: hw/cpu_queue_regs_pkg.sv
// register map: apb address width, register offsets, control bit positions

package cpu_queue_regs_pkg;

   localparam int APB_ADDR_WIDTH = 8;

   // control and watchdog limit, read/write
   localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL        = 8'h00;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_WD_LIMIT    = 8'h04;

   // event counters, read only, host-relative naming
   localparam logic [APB_ADDR_WIDTH-1:0] REG_RX_STORED   = 8'h08;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_RX_PULLED   = 8'h0C;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_TX_STORED   = 8'h10;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_TX_SENT     = 8'h14;
   localparam logic [APB_ADDR_WIDTH-1:0] REG_TX_TIMEOUTS = 8'h18;

   // REG_CTRL fields
   localparam int CTRL_RX_EN_BIT = 0;
   localparam int CTRL_TX_EN_BIT = 1;

endpackage

// File: hw/cpu_queue_pkg.sv
// datapath constants: packet counter width, fifo slack, watchdog timer width

package cpu_queue_pkg;

   ////////////////////////////////////////
   // fifo bookkeeping
   ////////////////////////////////////////

   // one complete-packet counter, enough for a full 32 entry fifo
   localparam int PKT_CNT_WIDTH = 6;

   // free entries left when almost_full rises
   // covers words already in flight from the source
   localparam int FIFO_SLACK = 4;

   ////////////////////////////////////////
   // tx lock-up watchdog
   ////////////////////////////////////////

   // limit register and down counter share this width
   localparam int WD_TIMER_WIDTH = 32;

endpackage
